// ==== files.f ====
hw/pdp8Pkg.sv
hw/coreMemory.sv
hw/panelControl.sv
hw/instrSequencer.sv
hw/accUnit.sv
hw/panelLights.sv
hw/pdp8Top.sv
sim/pdp8Tb_asserts.sv
sim/pdp8Tb.sv

// ==== Makefile ====
# Verilator build and run for the PDP-8 testbench
VERILATOR ?= verilator
TOP       ?= pdp8Tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/pdp8Tb.sv ====
// Directed testbench for the PDP-8 top level. Programs are entered
// through the panel strobes, run to HLT and read back on the display.
// Expected values follow the PDP-8 instruction rules.
`timescale 1ns/100ps

module pdp8Tb
  import pdp8Pkg::*;
();

  localparam int clkPeriod  = 4;
  localparam int runBound   = 200;
  // Program runs and panel-only sequences, each with slack for panel work
  localparam int runCount   = 48;
  localparam int watchdogNs = runCount * (runBound + 120) * clkPeriod;

  // Operate words, octal 7300 7402 7100 7120 7041 7010 7006 7012
  localparam word_t claCll = 12'hEC0;
  localparam word_t hlt    = 12'hF02;
  localparam word_t cll    = 12'hE40;
  localparam word_t cllCml = 12'hE50;
  localparam word_t cmaIac = 12'hE21;
  localparam word_t rar    = 12'hE08;
  localparam word_t rtl    = 12'hE06;
  localparam word_t rtr    = 12'hE0A;

  logic        clk;
  logic        rstN;
  word_t       switches;
  logic        loadAddr;
  logic        deposit;
  logic        start;
  dispSel_t    dispSel;
  word_t       display;
  logic        linkLight;
  logic        runLight;
  logic [31:0] lfsr;

  pdp8Top #(.memWords(4096)) dut (
    .clk      (clk),
    .rstN     (rstN),
    .switches (switches),
    .loadAddr (loadAddr),
    .deposit  (deposit),
    .start    (start),
    .dispSel  (dispSel),
    .display  (display),
    .linkLight(linkLight),
    .runLight (runLight)
  );

  bind instrSequencer seqAsserts seqChecks (
    .clk    (clk),
    .rstN   (rstN),
    .state  (state),
    .memWe  (memWe),
    .panelWe(panelWe),
    .running(running),
    .pcLoad (pcLoad),
    .pcStep (pcStep),
    .pc     (pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  initial begin
    #(watchdogNs);
    failRun("Timeout: the tests did not finish within the watchdog limit");
  end

  // Bound sequencer checker
  always @(negedge clk) begin
    assert (!dut.theSeq.seqChecks.anyFail) else
      failRun("A sequencer assertion failed");
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic word_t randBits(input int count);
    word_t value;
    logic  fb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value[i] = fb;
    end
    return value;
  endfunction

  function automatic word_t randWord();
    return randBits(wordW);
  endfunction

  // Memory reference word, current page assumed for any page above zero
  function automatic word_t mri(input logic [2:0] op, input logic ind, input word_t addr);
    logic onPage;
    onPage = (addr[wordW-1:offsetW] != '0);
    return {op, ind, onPage, addr[offsetW-1:0]};
  endfunction

  // 13-bit rotate of link:AC
  function automatic logic [wordW:0] rotRight(input logic [wordW:0] lac);
    return (lac >> 1) | (lac << wordW);
  endfunction

  function automatic logic [wordW:0] rotLeft(input logic [wordW:0] lac);
    return (lac << 1) | (lac >> wordW);
  endfunction

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      failRun("Value check failed");
    end
  endtask

  task automatic loadAddress(input word_t addr);
    @(posedge clk);
    switches <= addr;
    loadAddr <= 1'b1;
    @(posedge clk);
    loadAddr <= 1'b0;
  endtask

  // Writes at the PC, which then steps by one
  task automatic depositWord(input word_t value);
    @(posedge clk);
    switches <= value;
    deposit  <= 1'b1;
    @(posedge clk);
    deposit <= 1'b0;
  endtask

  task automatic storeWord(input word_t addr, input word_t value);
    loadAddress(addr);
    depositWord(value);
  endtask

  task automatic readDisplay(input dispSel_t sel, output word_t value);
    @(posedge clk);
    dispSel <= sel;
    repeat (3) @(posedge clk);
    @(negedge clk);
    value = display;
  endtask

  task automatic examine(input word_t addr, output word_t value);
    loadAddress(addr);
    readDisplay(showMem, value);
  endtask

  task automatic waitRun(input logic level, input int bound);
    int count;
    count = 0;
    while (runLight !== level) begin
      @(negedge clk);
      count++;
      assert (count <= bound) else
        failRun("The run light did not change within the cycle bound");
    end
  endtask

  task automatic runUntilHalt(input word_t addr, input int bound);
    loadAddress(addr);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    waitRun(1'b1, 8);
    waitRun(1'b0, bound);
  endtask

  task automatic depositAndExamine();
    word_t words [8];
    word_t got;
    loadAddress(12'h300);
    foreach (words[i]) begin
      words[i] = randWord();
      depositWord(words[i]);
      readDisplay(showPc, got);
      checkWord("display as PC after deposit", got, word_t'(12'h301 + i));
    end
    foreach (words[i]) begin
      examine(word_t'(12'h300 + i), got);
      checkWord("display as deposited word", got, words[i]);
    end
  endtask

  task automatic addAndStore();
    word_t          a;
    word_t          b;
    word_t          got;
    logic [wordW:0] total;
    a = randWord();
    b = randWord();
    total = {1'b0, a} + {1'b0, b};
    loadAddress(12'h080);
    depositWord(claCll);
    depositWord(mri(opTad, 1'b0, 12'h0E0));
    depositWord(mri(opTad, 1'b0, 12'h0E1));
    depositWord(mri(opDca, 1'b0, 12'h0E2));
    depositWord(hlt);
    storeWord(12'h0E0, a);
    depositWord(b);
    depositWord(~total[wordW-1:0]);
    runUntilHalt(12'h080, runBound);
    readDisplay(showAc, got);
    checkWord("display as AC after DCA", got, '0);
    checkWord("linkLight", word_t'(linkLight), word_t'(total[wordW]));
    examine(12'h0E2, got);
    checkWord("display as TAD sum", got, total[wordW-1:0]);
  endtask

  // Indirect through a current page pointer, then a direct page zero operand
  task automatic maskWithAnd();
    word_t x;
    word_t y;
    word_t z;
    word_t got;
    x = randWord();
    y = randWord();
    z = randWord();
    loadAddress(12'h080);
    depositWord(claCll);
    depositWord(mri(opTad, 1'b0, 12'h0E0));
    depositWord(mri(opAnd, 1'b1, 12'h0E1));
    depositWord(mri(opAnd, 1'b0, 12'h020));
    depositWord(mri(opDca, 1'b0, 12'h0E2));
    depositWord(hlt);
    storeWord(12'h0E0, x);
    depositWord(12'h300);
    depositWord(~(x & y & z));
    storeWord(12'h300, y);
    storeWord(12'h020, z);
    runUntilHalt(12'h080, runBound);
    examine(12'h0E2, got);
    checkWord("display as AND result", got, x & y & z);
  endtask

  task automatic operateGroup1();
    word_t          x;
    word_t          y;
    word_t          z;
    word_t          w;
    word_t          got;
    word_t          r2;
    word_t          r3;
    logic [wordW:0] lac;
    x = randWord();
    y = randWord();
    z = randWord();
    w = randWord();
    // Link set by CLL CML, then RAR, RTL and RTR on fresh AC values
    lac = rotRight({1'b1, y});
    r2  = lac[wordW-1:0];
    lac = rotLeft(rotLeft({lac[wordW], z}));
    r3  = lac[wordW-1:0];
    lac = rotRight(rotRight({lac[wordW], w}));
    loadAddress(12'h080);
    depositWord(claCll);
    depositWord(mri(opTad, 1'b0, 12'h0E0));
    depositWord(cmaIac);
    depositWord(mri(opDca, 1'b0, 12'h0E4));
    depositWord(cllCml);
    depositWord(mri(opTad, 1'b0, 12'h0E1));
    depositWord(rar);
    depositWord(mri(opDca, 1'b0, 12'h0E5));
    depositWord(mri(opTad, 1'b0, 12'h0E2));
    depositWord(rtl);
    depositWord(mri(opDca, 1'b0, 12'h0E6));
    depositWord(mri(opTad, 1'b0, 12'h0E3));
    depositWord(rtr);
    depositWord(hlt);
    storeWord(12'h0E0, x);
    depositWord(y);
    depositWord(z);
    depositWord(w);
    // Complements mark any DCA that never landed
    depositWord(~(~x + word_t'(1)));
    depositWord(~r2);
    depositWord(~r3);
    runUntilHalt(12'h080, runBound);
    readDisplay(showAc, got);
    checkWord("display as AC after RTR", got, lac[wordW-1:0]);
    checkWord("linkLight", word_t'(linkLight), word_t'(lac[wordW]));
    examine(12'h0E4, got);
    checkWord("display as negated word", got, ~x + word_t'(1));
    examine(12'h0E5, got);
    checkWord("display as RAR result", got, r2);
    examine(12'h0E6, got);
    checkWord("display as RTL result", got, r3);
  endtask

  // ISZ loop adds one per pass, then a JMS and a JMP I return
  task automatic countAndCall();
    word_t n;
    word_t k;
    word_t got;
    n = randBits(3) + word_t'(1);
    k = randWord();
    loadAddress(12'h080);
    depositWord(claCll);
    depositWord(mri(opTad, 1'b0, 12'h0E2));
    depositWord(mri(opIsz, 1'b0, 12'h0E0));
    depositWord(mri(opJmp, 1'b0, 12'h081));
    depositWord(mri(opDca, 1'b0, 12'h0E3));
    depositWord(mri(opJms, 1'b0, 12'h0C0));
    depositWord(hlt);
    storeWord(12'h0C0, '0);
    depositWord(mri(opTad, 1'b0, 12'h0E4));
    depositWord(mri(opDca, 1'b0, 12'h0E5));
    depositWord(mri(opJmp, 1'b1, 12'h0C0));
    storeWord(12'h0E0, ~n + word_t'(1));
    depositWord('0);
    depositWord(12'h001);
    depositWord('0);
    depositWord(k);
    depositWord(~k);
    runUntilHalt(12'h080, runBound);
    readDisplay(showPc, got);
    checkWord("display as PC after HLT", got, 12'h087);
    examine(12'h0E0, got);
    checkWord("display as ISZ counter", got, '0);
    examine(12'h0E3, got);
    checkWord("display as iteration count", got, n);
    examine(12'h0C0, got);
    checkWord("display as JMS return address", got, 12'h086);
    examine(12'h0E5, got);
    checkWord("display as subroutine result", got, k);
  endtask

  // The DCA marker only lands when the skip is not taken
  task automatic skipCase(input word_t value, input logic linkSet, input word_t instr,
                          input logic expSkip);
    word_t got;
    loadAddress(12'h080);
    depositWord(claCll);
    depositWord(mri(opTad, 1'b0, 12'h0E0));
    depositWord(linkSet ? cllCml : cll);
    depositWord(instr);
    depositWord(mri(opDca, 1'b0, 12'h0E1));
    depositWord(hlt);
    storeWord(12'h0E0, value);
    depositWord(~value);
    runUntilHalt(12'h080, runBound);
    examine(12'h0E1, got);
    checkWord("display as skip marker", got, expSkip ? ~value : value);
  endtask

  task automatic skipGroup2();
    word_t      values [3];
    word_t      instrs [6];
    word_t      v;
    logic       linkSet;
    logic [5:0] expSkip;
    values[0] = randWord() | 12'h800;
    values[1] = '0;
    values[2] = (randWord() & 12'h7FF) | 12'h001;
    // SMA SZA SNL SPA SNA SZL
    instrs = '{12'hF40, 12'hF20, 12'hF10, 12'hF48, 12'hF28, 12'hF18};
    for (int vi = 0; vi < 3; vi++) begin
      for (int li = 0; li < 2; li++) begin
        v = values[vi];
        linkSet = (li == 1);
        expSkip = {!linkSet, v != '0, !v[wordW-1], linkSet, v == '0, v[wordW-1]};
        for (int si = 0; si < 6; si++) begin
          skipCase(v, linkSet, instrs[si], expSkip[si]);
        end
      end
    end
  endtask

  initial begin
    lfsr     = 32'h7dcb;
    rstN     = 1'b0;
    switches = '0;
    loadAddr = 1'b0;
    deposit  = 1'b0;
    start    = 1'b0;
    dispSel  = showPc;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    depositAndExamine();
    addAndStore();
    maskWithAnd();
    operateGroup1();
    countAndCall();
    skipGroup2();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sim/pdp8Tb_asserts.sv ====
// Protocol checks on the sequencer, attached with bind.
// Reports only through assertion failures.
`timescale 1ns/100ps

module seqAsserts
  import pdp8Pkg::*;
(
  input logic   clk,
  input logic   rstN,
  input state_t state,
  input logic   memWe,
  input logic   panelWe,
  input logic   running,
  input logic   pcLoad,
  input logic   pcStep,
  input word_t  pc
);

  // Sticky failure flags
  logic fetchFail = 1'b0;
  logic panelFail = 1'b0;
  logic pcFail    = 1'b0;
  logic anyFail;

  assign anyFail = fetchFail | panelFail | pcFail;

  // Fetch only reads the instruction
  fetchNoWrite: assert property (@(posedge clk) disable iff (!rstN)
    state == fetch |-> !memWe)
    else begin
      $error("Memory write while in the fetch state");
      fetchFail = 1'b1;
    end

  panelWriteHalted: assert property (@(posedge clk) disable iff (!rstN)
    panelWe |-> !running)
    else begin
      $error("Panel write while the machine is running");
      panelFail = 1'b1;
    end

  // PC moves only on a panel load or step, or out of fetch and execute
  pcMoveCause: assert property (@(posedge clk) disable iff (!rstN)
    !$stable(pc) |-> $past(pcLoad || pcStep || state == fetch || state == execute))
    else begin
      $error("PC changed without a load, a step or a state advance");
      pcFail = 1'b1;
    end

endmodule

// ==== hw/pdp8Top.sv ====
// Cut-down PDP-8 with a minimal front panel.
// No interrupts, no IOT devices, no MQ/EAE. IOT runs as a no-op.
// memWords must be a power of two, at least 256; addresses wrap.
`timescale 1ns/100ps

module pdp8Top
  import pdp8Pkg::*;
#(
  parameter int memWords = 4096
) (
  input  logic     clk,
  input  logic     rstN,
  input  word_t    switches,
  input  logic     loadAddr,
  input  logic     deposit,
  input  logic     start,
  input  dispSel_t dispSel,
  output word_t    display,
  output logic     linkLight,
  output logic     runLight
);

  logic       pcLoad;
  word_t      pcLoadValue;
  logic       pcStep;
  logic       panelWe;
  word_t      panelData;
  logic       runReq;
  logic       running;
  word_t      memAddr;
  logic       memWe;
  word_t      memWdata;
  word_t      memRdata;
  logic [2:0] acOp;
  word_t      ir;
  word_t      pc;
  word_t      ac;
  logic       link;
  logic       skip;

  panelControl thePanel (
    .clk        (clk),
    .rstN       (rstN),
    .switches   (switches),
    .loadAddr   (loadAddr),
    .deposit    (deposit),
    .start      (start),
    .running    (running),
    .pcLoad     (pcLoad),
    .pcLoadValue(pcLoadValue),
    .pcStep     (pcStep),
    .panelWe    (panelWe),
    .panelData  (panelData),
    .runReq     (runReq)
  );

  instrSequencer #(.memWords(memWords)) theSeq (
    .clk        (clk),
    .rstN       (rstN),
    .pcLoad     (pcLoad),
    .pcLoadValue(pcLoadValue),
    .pcStep     (pcStep),
    .panelWe    (panelWe),
    .panelData  (panelData),
    .runReq     (runReq),
    .memRdata   (memRdata),
    .ac         (ac),
    .skip       (skip),
    .memAddr    (memAddr),
    .memWe      (memWe),
    .memWdata   (memWdata),
    .acOp       (acOp),
    .ir         (ir),
    .pc         (pc),
    .running    (running)
  );

  accUnit theAcc (
    .clk    (clk),
    .rstN   (rstN),
    .acOp   (acOp),
    .operand(memRdata),
    .ir     (ir),
    .ac     (ac),
    .link   (link),
    .skip   (skip)
  );

  coreMemory #(.memWords(memWords)) theMem (
    .clk  (clk),
    .addr (memAddr),
    .we   (memWe),
    .wdata(memWdata),
    .rdata(memRdata)
  );

  panelLights theLights (
    .clk      (clk),
    .rstN     (rstN),
    .dispSel  (dispSel),
    .pc       (pc),
    .ac       (ac),
    .memWord  (memRdata),
    .link     (link),
    .running  (running),
    .display  (display),
    .linkLight(linkLight),
    .runLight (runLight)
  );

endmodule

// ==== hw/panelLights.sv ====
// Front panel output side, one register stage on every light.
// The memory view shows the word last read, which is the word
// at the PC while the machine is halted.
`timescale 1ns/100ps

module panelLights
  import pdp8Pkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  dispSel_t dispSel,
  input  word_t    pc,
  input  word_t    ac,
  input  word_t    memWord,
  input  logic     link,
  input  logic     running,
  output word_t    display,
  output logic     linkLight,
  output logic     runLight
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      display   <= '0;
      linkLight <= 1'b0;
      runLight  <= 1'b0;
    end else begin
      case (dispSel)
        showPc:  display <= pc;
        showAc:  display <= ac;
        showMem: display <= memWord;
        default: display <= '0;
      endcase
      linkLight <= link;
      runLight  <= running;
    end
  end

endmodule

// ==== hw/accUnit.sv ====
// Accumulator and link. Group 1 runs CLA/CLL, CMA/CML, IAC, then rotate.
// Skip is combinational from the AC and link before any group 2 CLA
// and is only meaningful while the IR holds a group 2 word.
`timescale 1ns/100ps

module accUnit
  import pdp8Pkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic [2:0] acOp,
  input  word_t      operand,
  input  word_t      ir,
  output word_t      ac,
  output logic       link,
  output logic       skip
);

  logic [wordW:0] sum;
  logic [wordW:0] lac;
  logic           skipCond;

  assign sum = {1'b0, ac} + {1'b0, operand};

  // SMA, SZA, SNL ored, IR[3] flips to SPA, SNA, SZL anded
  assign skipCond = (ir[6] & ac[wordW-1]) | (ir[5] & (ac == '0)) | (ir[4] & link);
  assign skip     = ir[3] ? ~skipCond : skipCond;

  // Group 1 on the 13-bit link:AC pair
  always_comb begin
    lac = {link, ac};
    if (ir[7]) begin
      lac[wordW-1:0] = '0;
    end
    if (ir[6]) begin
      lac[wordW] = 1'b0;
    end
    if (ir[5]) begin
      lac[wordW-1:0] = ~lac[wordW-1:0];
    end
    if (ir[4]) begin
      lac[wordW] = ~lac[wordW];
    end
    // Carry out of the AC lands in the link bit and flips it
    if (ir[0]) begin
      lac = lac + {{wordW{1'b0}}, 1'b1};
    end
    if (ir[3]) begin
      lac = {lac[0], lac[wordW:1]};
      if (ir[1]) begin
        lac = {lac[0], lac[wordW:1]};
      end
    end else if (ir[2]) begin
      lac = {lac[wordW-1:0], lac[wordW]};
      if (ir[1]) begin
        lac = {lac[wordW-1:0], lac[wordW]};
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (acOp)
        acAnd:    ac <= ac & operand;
        acTad: begin
          ac   <= sum[wordW-1:0];
          link <= link ^ sum[wordW];
        end
        acDcaClr: ac <= '0;
        acGrp1:   {link, ac} <= lac;
        acGrp2: begin
          if (ir[7]) begin
            ac <= '0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/instrSequencer.sv ====
// Non-pipelined PDP-8 sequencer. The instruction arrives in fetch, so
// the cycle before fetch always presents the next PC to memory.
// Autoindex locations behave as plain indirect. Group 3 and IOT are no-ops.
// memWords must be a power of two; PC and addresses wrap modulo memWords.
`timescale 1ns/100ps

module instrSequencer
  import pdp8Pkg::*;
#(
  parameter int memWords = 4096
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       pcLoad,
  input  word_t      pcLoadValue,
  input  logic       pcStep,
  input  logic       panelWe,
  input  word_t      panelData,
  input  logic       runReq,
  input  word_t      memRdata,
  input  word_t      ac,
  input  logic       skip,
  output word_t      memAddr,
  output logic       memWe,
  output word_t      memWdata,
  output logic [2:0] acOp,
  output word_t      ir,
  output word_t      pc,
  output logic       running
);

  localparam word_t addrMask = word_t'(memWords - 1);

  state_t     state;
  state_t     nextState;
  word_t      ea;
  word_t      pcNext;
  word_t      pcInc;
  word_t      instrAddr;
  word_t      iszValue;
  logic [2:0] fetchOp;
  logic [2:0] opcode;

  assign fetchOp  = memRdata[wordW-1 -: 3];
  assign opcode   = ir[wordW-1 -: 3];
  assign pcInc    = (pc + word_t'(1)) & addrMask;
  assign iszValue = memRdata + word_t'(1);
  assign running  = (state != idle);

  // Page zero or current page, from the word arriving in fetch
  always_comb begin
    instrAddr = '0;
    instrAddr[offsetW-1:0] = memRdata[offsetW-1:0];
    if (memRdata[pageBit]) begin
      instrAddr[wordW-1:offsetW] = pc[wordW-1:offsetW];
    end
    instrAddr = instrAddr & addrMask;
  end

  always_comb begin
    nextState = state;
    pcNext    = pc;
    memAddr   = pc;
    memWe     = 1'b0;
    memWdata  = panelData;
    acOp      = acNone;
    case (state)
      idle: begin
        memWe = panelWe;
        if (runReq) begin
          nextState = fetch;
        end
      end
      fetch: begin
        pcNext  = pcInc;
        // Pointer for indirect, operand otherwise
        memAddr = instrAddr;
        if (fetchOp < opIot && memRdata[indBit]) begin
          nextState = defer;
        end else begin
          nextState = execute;
        end
      end
      defer: begin
        memAddr   = memRdata & addrMask;
        nextState = execute;
      end
      execute: begin
        nextState = fetch;
        case (opcode)
          opAnd: acOp = acAnd;
          opTad: acOp = acTad;
          opIsz: begin
            memAddr   = ea;
            memWe     = 1'b1;
            memWdata  = iszValue;
            nextState = writeBack;
            if (iszValue == '0) begin
              pcNext = pcInc;
            end
          end
          opDca: begin
            memAddr   = ea;
            memWe     = 1'b1;
            memWdata  = ac;
            acOp      = acDcaClr;
            nextState = writeBack;
          end
          opJms: begin
            memAddr   = ea;
            memWe     = 1'b1;
            memWdata  = pc;
            pcNext    = (ea + word_t'(1)) & addrMask;
            nextState = writeBack;
          end
          opJmp: pcNext = ea;
          opIot: acOp = acNone;
          opOpr: begin
            // IR[8] picks the group, IR[0] marks group 3
            if (!ir[8]) begin
              acOp = acGrp1;
            end else if (!ir[0]) begin
              acOp = acGrp2;
              if (skip) begin
                pcNext = pcInc;
              end
              if (ir[1]) begin
                nextState = idle;
              end
            end
          end
        endcase
        // No write this cycle, so start reading the next instruction
        if (!memWe) begin
          memAddr = pcNext;
        end
      end
      writeBack: nextState = fetch;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
      pc    <= '0;
      ir    <= '0;
    end else begin
      state <= nextState;
      if (state == idle) begin
        if (pcLoad) begin
          pc <= pcLoadValue & addrMask;
        end else if (pcStep) begin
          pc <= pcInc;
        end
      end else begin
        pc <= pcNext;
      end
      if (state == fetch) begin
        ir <= memRdata;
      end
    end
  end

  // Effective address, replaced by the pointer on defer
  always_ff @(posedge clk) begin
    if (state == fetch) begin
      ea <= instrAddr;
    end else if (state == defer) begin
      ea <= memRdata & addrMask;
    end
  end

endmodule

// ==== hw/panelControl.sv ====
// Front panel input side. Strobes must be clean one-cycle pulses,
// synchronous to clk. Every output lags its strobe by one cycle and
// strobes seen while the machine runs are dropped.
`timescale 1ns/100ps

module panelControl
  import pdp8Pkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  word_t switches,
  input  logic  loadAddr,
  input  logic  deposit,
  input  logic  start,
  input  logic  running,
  output logic  pcLoad,
  output word_t pcLoadValue,
  output logic  pcStep,
  output logic  panelWe,
  output word_t panelData,
  output logic  runReq
);

  word_t switchReg;
  logic  halted;

  assign halted = ~running;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcLoad  <= 1'b0;
      panelWe <= 1'b0;
      runReq  <= 1'b0;
    end else begin
      pcLoad  <= loadAddr & halted;
      panelWe <= deposit & halted;
      runReq  <= start & halted;
    end
  end

  // Switch snapshot taken with the strobe
  always_ff @(posedge clk) begin
    switchReg <= switches;
  end

  // Deposit writes at the PC and steps it on the same edge
  assign pcStep      = panelWe;
  assign pcLoadValue = switchReg;
  assign panelData   = switchReg;

endmodule

// ==== hw/coreMemory.sv ====
// Single-port core memory with a registered read and no reset.
// A read during a write returns the old word.
// Only the low log2(memWords) address bits are used.
`timescale 1ns/100ps

module coreMemory #(
  parameter int memWords = 4096
) (
  input  logic        clk,
  input  logic [11:0] addr,
  input  logic        we,
  input  logic [11:0] wdata,
  output logic [11:0] rdata
);

  localparam int addrW = $clog2(memWords);

  logic [11:0] mem [memWords];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[addrW-1:0]] <= wdata;
    end
    rdata <= mem[addr[addrW-1:0]];
  end

endmodule

// ==== hw/pdp8Pkg.sv ====
// Shared definitions for the cut-down PDP-8 processor.
// Machine words are 12 bits. Opcodes, operate bits and the IR fields
// follow standard PDP-8 numbering, with bit 0 as the LSB here.
package pdp8Pkg;

  localparam int wordW = 12;

  typedef logic [wordW-1:0] word_t;

  // Major opcodes in IR[11:9]
  localparam logic [2:0] opAnd = 3'd0;
  localparam logic [2:0] opTad = 3'd1;
  localparam logic [2:0] opIsz = 3'd2;
  localparam logic [2:0] opDca = 3'd3;
  localparam logic [2:0] opJms = 3'd4;
  localparam logic [2:0] opJmp = 3'd5;
  localparam logic [2:0] opIot = 3'd6;
  localparam logic [2:0] opOpr = 3'd7;

  // Memory reference fields
  localparam int indBit  = 8;
  localparam int pageBit = 7;
  localparam int offsetW = 7;

  // Accumulator unit strobe codes
  localparam logic [2:0] acNone   = 3'd0;
  localparam logic [2:0] acAnd    = 3'd1;
  localparam logic [2:0] acTad    = 3'd2;
  localparam logic [2:0] acDcaClr = 3'd3;
  localparam logic [2:0] acGrp1   = 3'd4;
  localparam logic [2:0] acGrp2   = 3'd5;

  typedef enum logic [2:0] {
    idle,
    fetch,
    defer,
    execute,
    writeBack
  } state_t;

  typedef enum logic [1:0] {
    showPc,
    showAc,
    showMem
  } dispSel_t;

endpackage
